// File: tsc_cpu.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/alu.sv
logic/control_unit.sv
logic/axi_lite_master.sv
logic/tsc_cpu.sv
dv/tsc_cpu_assert.sv
dv/tsc_checker.sv
dv/tsc_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tsc_cpu_tb
FILELIST ?= tsc_cpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tsc_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module tsc_cpu_tb;

	typedef enum {K_ADD, K_SUB, K_AND, K_ORR, K_NOT, K_TCP, K_SHL, K_SHR, K_ADI, K_ORI, K_LHI,
		K_BEQ, K_BNE, K_BGZ, K_BLZ, K_JMP, K_JAL, K_JPR, K_JRL, K_MEM, K_OVF} kind_e;

	typedef struct {
		string name;
		kind_e kind;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] exp_val;
	} row_t;

	logic clk;
	logic reset;
	logic arready, rvalid, awready, wready, bvalid;
	logic [1:0] rresp, bresp;
	logic [15:0] rdata;
	wire [15:0] araddr, awaddr, wdata, output_port;
	wire arvalid, rready, awvalid, wvalid, bready, output_valid, halted, overflow_trap;
	logic expect_trap;

	logic [15:0] mem [0:1023];
	row_t rows[$];
	int pc_w;
	int limit;
	int cycles;

	tsc_cpu uut (.*);

	tsc_checker chk (.clk(clk), .reset(reset), .output_port(output_port),
		.output_valid(output_valid), .halted(halted), .overflow_trap(overflow_trap),
		.expect_trap(expect_trap));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// AXI4-Lite memory model
	int ar_delay, aw_delay, w_delay;
	logic aw_done, w_done;
	logic [15:0] wr_addr, wr_data;

	always @(posedge clk) begin : slave
		logic s_arv, s_arr, s_rr, s_awv, s_awr, s_wv, s_wr, s_br;
		logic [15:0] s_araddr, s_awaddr, s_wdata;
		s_arv = arvalid;
		s_arr = arready;
		s_rr = rready;
		s_awv = awvalid;
		s_awr = awready;
		s_wv = wvalid;
		s_wr = wready;
		s_br = bready;
		s_araddr = araddr;
		s_awaddr = awaddr;
		s_wdata = wdata;
		#2;
		if (reset) begin
			arready = 0;
			rvalid = 0;
			awready = 0;
			wready = 0;
			bvalid = 0;
			aw_done = 0;
			w_done = 0;
		end else begin
			if (rvalid && s_rr)
				rvalid = 0;
			if (s_arv && s_arr) begin
				arready = 0;
				rvalid = 1;
				rdata = mem[s_araddr[9:0]];
				ar_delay = $urandom % 4;
			end else if (s_arv) begin
				if (ar_delay == 0) arready = 1;
				else ar_delay--;
			end
			if (bvalid && s_br)
				bvalid = 0;
			if (s_awv && s_awr) begin
				awready = 0;
				aw_done = 1;
				wr_addr = s_awaddr;
				aw_delay = $urandom % 4;
			end else if (s_awv) begin
				if (aw_delay == 0) awready = 1;
				else aw_delay--;
			end
			if (s_wv && s_wr) begin
				wready = 0;
				w_done = 1;
				wr_data = s_wdata;
				w_delay = $urandom % 4;
			end else if (s_wv) begin
				if (w_delay == 0) wready = 1;
				else w_delay--;
			end
			if (aw_done && w_done) begin
				mem[wr_addr[9:0]] = wr_data;
				bvalid = 1;
				aw_done = 0;
				w_done = 0;
			end
		end
	end

	// ------------------------------
	// Program assembly
	function automatic logic [15:0] enc_i(isa_pkg::opcode_e op, logic [1:0] rs, logic [1:0] rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_r(isa_pkg::func_e fn, logic [1:0] rs, logic [1:0] rt,
		logic [1:0] rd);
		return {isa_pkg::ALU, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_j(isa_pkg::opcode_e op, logic [11:0] target);
		return {op, target};
	endfunction

	task add_row(input string name, input kind_e kind, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] exp_val);
		row_t r;
		r.name = name;
		r.kind = kind;
		r.a = a;
		r.b = b;
		r.exp_val = exp_val;
		rows.push_back(r);
	endtask

	task emit(input logic [15:0] word);
		mem[pc_w] = word;
		pc_w++;
	endtask

	task build_program(input bit overflow_run);
		int p;
		int n;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] exp_val;
		kind_e k;
		logic [1:0] show_reg;
		for (int i = 0; i < 1024; i++)
			mem[i] = 16'(i) ^ 16'ha5c3;   // Background, never executed
		pc_w = 0;
		n = 0;
		foreach (rows[i]) begin
			k = rows[i].kind;
			if ((k == K_OVF) != overflow_run)
				continue;
			p = pc_w;
			a = (k == K_JPR || k == K_JRL) ? 16'(p + 6) : rows[i].a;
			b = rows[i].b;
			exp_val = (k == K_JAL || k == K_JRL) ? 16'(p + 5) : rows[i].exp_val;
			emit(enc_i(isa_pkg::LHI, 0, 0, a[15:8]));
			emit(enc_i(isa_pkg::ORI, 0, 0, a[7:0]));
			emit(enc_i(isa_pkg::LHI, 0, 1, b[15:8]));
			emit(enc_i(isa_pkg::ORI, 1, 1, b[7:0]));
			case (k)
				K_ADD, K_OVF: emit(enc_r(isa_pkg::ADD, 0, 1, 3));
				K_SUB: emit(enc_r(isa_pkg::SUB, 0, 1, 3));
				K_AND: emit(enc_r(isa_pkg::AND, 0, 1, 3));
				K_ORR: emit(enc_r(isa_pkg::ORR, 0, 1, 3));
				K_NOT: emit(enc_r(isa_pkg::NOT, 0, 1, 3));
				K_TCP: emit(enc_r(isa_pkg::TCP, 0, 1, 3));
				K_SHL: emit(enc_r(isa_pkg::SHL, 0, 1, 3));
				K_SHR: emit(enc_r(isa_pkg::SHR, 0, 1, 3));
				K_ADI: emit(enc_i(isa_pkg::ADI, 0, 3, b[7:0]));
				K_ORI: emit(enc_i(isa_pkg::ORI, 0, 3, b[7:0]));
				K_LHI: emit(enc_i(isa_pkg::LHI, 0, 3, b[7:0]));
				K_BEQ: emit(enc_i(isa_pkg::BEQ, 0, 1, 8'd1));   // Skip one word
				K_BNE: emit(enc_i(isa_pkg::BNE, 0, 1, 8'd1));
				K_BGZ: emit(enc_i(isa_pkg::BGZ, 0, 1, 8'd1));
				K_BLZ: emit(enc_i(isa_pkg::BLZ, 0, 1, 8'd1));
				K_JMP: emit(enc_j(isa_pkg::JMP, 12'(p + 6)));
				K_JAL: emit(enc_j(isa_pkg::JAL, 12'(p + 6)));
				K_JPR: emit(enc_r(isa_pkg::JPR, 0, 0, 0));
				K_JRL: emit(enc_r(isa_pkg::JRL, 0, 0, 0));
				default: begin
					emit(enc_i(isa_pkg::SWD, 1, 0, 8'd0));
					emit(enc_i(isa_pkg::LWD, 1, 3, 8'd0));
				end
			endcase
			if (k >= K_BEQ && k <= K_JRL) begin
				show_reg = (k == K_JAL || k == K_JRL) ? 2'd2 : 2'd1;
				emit(enc_i(isa_pkg::ADI, show_reg, show_reg, 8'h40));   // Marker, plus 0x40
				emit(enc_r(isa_pkg::WWD, show_reg, 0, 0));
			end else begin
				emit(enc_r(isa_pkg::WWD, 3, 0, 0));
			end
			if (k != K_OVF)
				chk.push_expected(rows[i].name, exp_val);
			n++;
		end
		emit(enc_r(isa_pkg::HLT, 0, 0, 0));
		limit = (n + 1) * 12 * 16;
	endtask

	task run_program(input bit overflow_run);
		#2 reset = 1;
		expect_trap = overflow_run;
		build_program(overflow_run);
		repeat (2) @(posedge clk);
		#2 reset = 0;
		cycles = 0;
		while (!halted && cycles < limit) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halted) begin
			$display("timeout, core did not halt within %0d cycles", limit);
			$display("tests failed");
			$finish;
		end
		repeat (2) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'h8497_3ae9));
		reset = 1;
		arready = 0;
		rvalid = 0;
		rdata = '0;
		rresp = 2'b00;
		awready = 0;
		wready = 0;
		bvalid = 0;
		bresp = 2'b00;
		expect_trap = 0;
		ar_delay = $urandom % 4;
		aw_delay = $urandom % 4;
		w_delay = $urandom % 4;
		add_row("add", K_ADD, 16'h1234, 16'hf0f0, 16'h0324);
		add_row("sub", K_SUB, 16'h1234, 16'hf0f0, 16'h2144);
		add_row("and", K_AND, 16'h1234, 16'hf0f0, 16'h1030);
		add_row("orr", K_ORR, 16'h1234, 16'hf0f0, 16'hf2f4);
		add_row("not", K_NOT, 16'h1234, 16'hf0f0, 16'hedcb);
		add_row("tcp", K_TCP, 16'h1234, 16'hf0f0, 16'hedcc);
		add_row("shl", K_SHL, 16'h8421, 16'h0000, 16'h0842);
		add_row("shr", K_SHR, 16'h8421, 16'h0000, 16'hc210);
		add_row("adi", K_ADI, 16'h1234, 16'h00fe, 16'h1232);
		add_row("ori", K_ORI, 16'h1234, 16'h0081, 16'h12b5);
		add_row("lhi", K_LHI, 16'h1234, 16'h00a5, 16'ha500);
		add_row("beq taken", K_BEQ, 16'h2222, 16'h2222, 16'h2222);
		add_row("beq not taken", K_BEQ, 16'h2222, 16'h3333, 16'h3373);
		add_row("bne taken", K_BNE, 16'h2222, 16'h3333, 16'h3333);
		add_row("bne not taken", K_BNE, 16'h4444, 16'h4444, 16'h4484);
		add_row("bgz taken", K_BGZ, 16'h0005, 16'h1000, 16'h1000);
		add_row("bgz not taken", K_BGZ, 16'hfffb, 16'h1000, 16'h1040);
		add_row("blz taken", K_BLZ, 16'h8000, 16'h1000, 16'h1000);
		add_row("blz not taken", K_BLZ, 16'h0000, 16'h1000, 16'h1040);
		add_row("jmp", K_JMP, 16'h0000, 16'h0777, 16'h0777);
		add_row("jal link", K_JAL, 16'h0000, 16'h0777, 16'h0000);
		add_row("jpr", K_JPR, 16'h0000, 16'h0666, 16'h0666);
		add_row("jrl link", K_JRL, 16'h0000, 16'h0666, 16'h0000);
		add_row("store load 0", K_MEM, 16'hbeef, 16'h0300, 16'hbeef);
		add_row("store load 1", K_MEM, 16'h1357, 16'h0301, 16'h1357);
		add_row("add overflow", K_OVF, 16'h7fff, 16'h0001, 16'h0000);
		run_program(1'b0);   // Ends in HLT
		run_program(1'b1);   // Ends in overflow trap
		$display("run complete, errors: %0d", chk.errors);
		if (chk.errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tsc_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module tsc_checker (
	input  logic clk,
	input  logic reset,
	input  logic [`TSC_WORD_BITS-1:0] output_port,
	input  logic output_valid,
	input  logic halted,
	input  logic overflow_trap,
	input  logic expect_trap
);

	string names[$];
	logic [`TSC_WORD_BITS-1:0] values[$];
	int errors;
	logic halted_prev;

	initial errors = 0;

	task push_expected(input string name, input logic [`TSC_WORD_BITS-1:0] value);
		names.push_back(name);
		values.push_back(value);
	endtask

	always @(posedge clk) begin : compare
		string name;
		logic [`TSC_WORD_BITS-1:0] value;
		if (reset) begin
			halted_prev <= 1'b0;
		end else begin
			halted_prev <= halted;
			// ------------------------------
			// Output beats, in program order
			if (output_valid) begin
				if (values.size() == 0) begin
					errors++;
					$display("unexpected output beat %h with no test waiting", output_port);
				end else begin
					name = names.pop_front();
					value = values.pop_front();
					if (output_port !== value) begin
						errors++;
						$display("[FAIL] %s expected %h actual %h", name, value, output_port);
					end
				end
			end
			if (halted && !halted_prev) begin
				if (values.size() != 0) begin
					errors++;
					$display("core halted with %0d output beats still missing", values.size());
					names.delete();
					values.delete();
				end
				if (overflow_trap !== expect_trap) begin
					errors++;
					$display("overflow trap is %b at halt but should be %b",
						overflow_trap, expect_trap);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tsc_cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module tsc_cpu_assert (
	input  logic clk,
	input  logic reset,
	input  logic [`TSC_WORD_BITS-1:0] araddr,
	input  logic arvalid,
	input  logic arready,
	input  logic [`TSC_WORD_BITS-1:0] awaddr,
	input  logic awvalid,
	input  logic awready,
	input  logic [`TSC_WORD_BITS-1:0] wdata,
	input  logic wvalid,
	input  logic wready,
	input  logic [1:0] rresp,
	input  logic rvalid,
	input  logic rready,
	input  logic [1:0] bresp,
	input  logic bvalid,
	input  logic bready
);

	// ------------------------------
	// Channels hold until handshake
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address moved or dropped before its handshake");
	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("write address moved or dropped before its handshake");
	w_hold: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("write data moved or dropped before its handshake");

	// One transaction at a time
	one_in_flight: assert property (@(posedge clk) disable iff (reset) !(rready && bready))
		else $error("read and write in flight together");

	r_okay: assert property (@(posedge clk) disable iff (reset) rvalid && rready |-> rresp == 2'b00)
		else $error("read response not OKAY");
	b_okay: assert property (@(posedge clk) disable iff (reset) bvalid && bready |-> bresp == 2'b00)
		else $error("write response not OKAY");

endmodule

bind axi_lite_master tsc_cpu_assert u_assert (.*);

`default_nettype wire

// File: logic/tsc_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module tsc_cpu (
	input  logic clk,
	input  logic reset,
	output logic [`TSC_WORD_BITS-1:0] araddr,
	output logic arvalid,
	input  logic arready,
	input  logic [`TSC_WORD_BITS-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rvalid,
	output logic rready,
	output logic [`TSC_WORD_BITS-1:0] awaddr,
	output logic awvalid,
	input  logic awready,
	output logic [`TSC_WORD_BITS-1:0] wdata,
	output logic wvalid,
	input  logic wready,
	input  logic [1:0] bresp,
	input  logic bvalid,
	output logic bready,
	output logic [`TSC_WORD_BITS-1:0] output_port,
	output logic output_valid,
	output logic halted,
	output logic overflow_trap
);

	isa_pkg::instr_u ir;
	logic [`TSC_WORD_BITS-1:0] pc;
	logic [`TSC_WORD_BITS-1:0] regs [`TSC_NUM_REGS];
	logic [`TSC_WORD_BITS-1:0] mdr;
	logic [`TSC_WORD_BITS-1:0] rs_val;
	logic [`TSC_WORD_BITS-1:0] rt_val;
	logic [`TSC_WORD_BITS-1:0] imm_sext;
	logic [`TSC_WORD_BITS-1:0] branch_target;
	logic [`TSC_WORD_BITS-1:0] alu_input_1;
	logic [`TSC_WORD_BITS-1:0] alu_input_2;
	logic [`TSC_WORD_BITS-1:0] alu_result;
	logic [`TSC_WORD_BITS-1:0] pc_next;
	logic [`TSC_WORD_BITS-1:0] wb_data;
	logic [`TSC_REG_BITS-1:0] wb_reg;
	logic [`TSC_WORD_BITS-1:0] mem_addr;
	logic [`TSC_WORD_BITS-1:0] mem_rdata;
	logic overflow_flag;
	logic bcond;
	logic pass_input_1;
	logic pass_input_2;
	logic mem_read;
	logic mem_write;
	logic mem_done;
	logic reg_write;
	logic ir_write;
	logic pc_write;
	logic is_wwd;
	core_pkg::state_e state;
	core_pkg::wb_src_e wb_src;
	core_pkg::pc_src_e pc_src;

	assign rs_val = regs[ir.r.rs];
	assign rt_val = regs[ir.r.rt];
	assign imm_sext = {{8{ir.i.imm[7]}}, ir.i.imm};
	assign branch_target = pc + imm_sext;   // PC already holds PC+1 here
	assign is_wwd = ir.r.opcode == isa_pkg::ALU && ir.r.func == isa_pkg::WWD;

	// ------------------------------
	// Operand muxes
	assign alu_input_1 = (ir.r.opcode == isa_pkg::JAL) ? pc : rs_val;

	always_comb begin
		case (ir.r.opcode)
			isa_pkg::ADI,
			isa_pkg::LWD,
			isa_pkg::SWD: alu_input_2 = imm_sext;
			isa_pkg::ORI: alu_input_2 = {8'h00, ir.i.imm};
			isa_pkg::LHI: alu_input_2 = {ir.i.imm, 8'h00};
			isa_pkg::JMP,
			isa_pkg::JAL: alu_input_2 = {pc[`TSC_WORD_BITS-1:12], ir.j.target};
			default: alu_input_2 = rt_val;   // R format and branch compare
		endcase
	end

	always_comb begin
		case (pc_src)
			core_pkg::PC_BRANCH: pc_next = branch_target;
			core_pkg::PC_JUMP_TARGET: pc_next = alu_result;
			core_pkg::PC_REGISTER: pc_next = rs_val;
			default: pc_next = pc + 1'b1;
		endcase
	end

	always_comb begin
		case (wb_src)
			core_pkg::WB_ALU: wb_data = alu_result;
			core_pkg::WB_MEM: wb_data = mdr;
			core_pkg::WB_PC_PLUS_1: wb_data = pc;
			default: wb_data = '0;
		endcase
	end

	assign wb_reg = (wb_src == core_pkg::WB_PC_PLUS_1) ? `TSC_REG_BITS'(2) :
		((ir.r.opcode == isa_pkg::ALU) ? ir.r.rd : ir.i.rt);
	assign mem_addr = (state == core_pkg::FETCH) ? pc : alu_result;

	// ------------------------------
	// Datapath registers
	always_ff @(posedge clk) begin
		if (reset)
			pc <= `TSC_RESET_PC;
		else if (pc_write)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (ir_write)
			ir <= mem_rdata;
		if (state == core_pkg::MEM_WAIT && mem_done)
			mdr <= mem_rdata;
		if (reg_write)
			regs[wb_reg] <= wb_data;
		if (state == core_pkg::EXECUTE && is_wwd)
			output_port <= rs_val;   // Shown in WRITEBACK
	end

	alu u_alu (
		.alu_input_1(alu_input_1),
		.alu_input_2(alu_input_2),
		.opcode(ir.r.opcode),
		.func_code(ir.r.func),
		.pass_input_1(pass_input_1),
		.pass_input_2(pass_input_2),
		.alu_result(alu_result),
		.overflow_flag(overflow_flag),
		.bcond(bcond)
	);

	control_unit u_control (
		.clk(clk),
		.reset(reset),
		.instr(ir),
		.bcond(bcond),
		.overflow_flag(overflow_flag),
		.mem_done(mem_done),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.state(state),
		.wb_src(wb_src),
		.pc_src(pc_src),
		.pass_input_1(pass_input_1),
		.pass_input_2(pass_input_2),
		.reg_write(reg_write),
		.ir_write(ir_write),
		.pc_write(pc_write),
		.output_valid(output_valid),
		.halted(halted),
		.overflow_trap(overflow_trap)
	);

	axi_lite_master u_bus (
		.clk(clk),
		.reset(reset),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(rt_val),
		.mem_rdata(mem_rdata),
		.mem_done(mem_done),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready)
	);

endmodule

`default_nettype wire

// File: logic/axi_lite_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module axi_lite_master (
	input  logic clk,
	input  logic reset,
	input  logic mem_read,
	input  logic mem_write,
	input  logic [`TSC_WORD_BITS-1:0] mem_addr,
	input  logic [`TSC_WORD_BITS-1:0] mem_wdata,
	output logic [`TSC_WORD_BITS-1:0] mem_rdata,
	output logic mem_done,
	output logic [`TSC_WORD_BITS-1:0] araddr,
	output logic arvalid,
	input  logic arready,
	input  logic [`TSC_WORD_BITS-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rvalid,
	output logic rready,
	output logic [`TSC_WORD_BITS-1:0] awaddr,
	output logic awvalid,
	input  logic awready,
	output logic [`TSC_WORD_BITS-1:0] wdata,
	output logic wvalid,
	input  logic wready,
	input  logic [1:0] bresp,
	input  logic bvalid,
	output logic bready
);

	logic busy;
	logic start_read;
	logic start_write;

	assign busy = rready || bready;   // One transaction in flight
	assign start_read = mem_read && !busy;
	assign start_write = mem_write && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			rready <= 1'b0;
			bready <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			// Read
			if (start_read) begin
				arvalid <= 1'b1;
				rready <= 1'b1;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (rvalid && rready) begin
				rready <= 1'b0;
				mem_done <= 1'b1;
			end
			// Write, address and data raised together
			if (start_write) begin
				awvalid <= 1'b1;
				wvalid <= 1'b1;
				bready <= 1'b1;
			end else begin
				if (awvalid && awready)
					awvalid <= 1'b0;
				if (wvalid && wready)
					wvalid <= 1'b0;
			end
			if (bvalid && bready) begin
				bready <= 1'b0;
				mem_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_read)
			araddr <= mem_addr;
		if (start_write) begin
			awaddr <= mem_addr;
			wdata <= mem_wdata;
		end
		if (rvalid && rready)
			mem_rdata <= rdata;
	end

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic clk,
	input  logic reset,
	input  isa_pkg::instr_u instr,
	input  logic bcond,
	input  logic overflow_flag,
	input  logic mem_done,
	output logic mem_read,
	output logic mem_write,
	output core_pkg::state_e state,
	output core_pkg::wb_src_e wb_src,
	output core_pkg::pc_src_e pc_src,
	output logic pass_input_1,
	output logic pass_input_2,
	output logic reg_write,
	output logic ir_write,
	output logic pc_write,
	output logic output_valid,
	output logic halted,
	output logic overflow_trap
);

	core_pkg::state_e state_next;
	core_pkg::pc_src_e pc_kind;
	logic is_alu_op;
	logic is_lwd;
	logic is_swd;
	logic is_jal;
	logic is_wwd;
	logic is_hlt;
	logic redirect;

	assign is_alu_op = instr.r.opcode == isa_pkg::ALU;
	assign is_lwd = instr.r.opcode == isa_pkg::LWD;
	assign is_swd = instr.r.opcode == isa_pkg::SWD;
	assign is_jal = instr.r.opcode == isa_pkg::JAL;
	assign is_wwd = is_alu_op && instr.r.func == isa_pkg::WWD;
	assign is_hlt = is_alu_op && instr.r.func == isa_pkg::HLT;

	// ------------------------------
	// Instruction decode
	always_comb begin
		wb_src = core_pkg::WB_NONE;
		pc_kind = core_pkg::PC_PLUS_1;
		case (instr.r.opcode)
			isa_pkg::ALU: begin
				case (instr.r.func)
					isa_pkg::JPR: pc_kind = core_pkg::PC_REGISTER;
					isa_pkg::JRL: begin
						pc_kind = core_pkg::PC_REGISTER;
						wb_src = core_pkg::WB_PC_PLUS_1;
					end
					isa_pkg::WWD,
					isa_pkg::HLT: wb_src = core_pkg::WB_NONE;
					default: wb_src = core_pkg::WB_ALU;
				endcase
			end
			isa_pkg::ADI,
			isa_pkg::ORI,
			isa_pkg::LHI: wb_src = core_pkg::WB_ALU;
			isa_pkg::LWD: wb_src = core_pkg::WB_MEM;
			isa_pkg::BNE,
			isa_pkg::BEQ,
			isa_pkg::BGZ,
			isa_pkg::BLZ: pc_kind = core_pkg::PC_BRANCH;
			isa_pkg::JMP: pc_kind = core_pkg::PC_JUMP_TARGET;
			isa_pkg::JAL: begin
				pc_kind = core_pkg::PC_JUMP_TARGET;
				wb_src = core_pkg::WB_PC_PLUS_1;   // Link into r2
			end
			default: wb_src = core_pkg::WB_NONE;
		endcase
	end

	assign redirect = (pc_kind == core_pkg::PC_BRANCH) ? bcond :
		(pc_kind != core_pkg::PC_PLUS_1);

	// ------------------------------
	// State sequencing
	always_comb begin
		state_next = state;
		case (state)
			core_pkg::FETCH: state_next = core_pkg::FETCH_WAIT;
			core_pkg::FETCH_WAIT: if (mem_done) state_next = core_pkg::DECODE;
			core_pkg::DECODE: state_next = core_pkg::EXECUTE;
			core_pkg::EXECUTE: begin
				if (is_hlt || overflow_flag)
					state_next = core_pkg::HALT;
				else if (is_lwd || is_swd)
					state_next = core_pkg::MEM;
				else
					state_next = core_pkg::WRITEBACK;
			end
			core_pkg::MEM: state_next = core_pkg::MEM_WAIT;
			core_pkg::MEM_WAIT: if (mem_done) state_next = core_pkg::WRITEBACK;
			core_pkg::WRITEBACK: state_next = core_pkg::FETCH;
			default: state_next = core_pkg::HALT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= core_pkg::FETCH;
			halted <= 1'b0;
			overflow_trap <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next == core_pkg::HALT)
				halted <= 1'b1;
			if (state == core_pkg::EXECUTE && overflow_flag)
				overflow_trap <= 1'b1;
		end
	end

	// Strobes, one cycle each
	assign mem_read = (state == core_pkg::FETCH) || (state == core_pkg::MEM && is_lwd);
	assign mem_write = state == core_pkg::MEM && is_swd;
	assign ir_write = state == core_pkg::FETCH_WAIT && mem_done;
	assign pc_write = (state == core_pkg::DECODE) || (state == core_pkg::WRITEBACK && redirect);
	assign pc_src = (state == core_pkg::WRITEBACK) ? pc_kind : core_pkg::PC_PLUS_1;
	assign reg_write = state == core_pkg::WRITEBACK && wb_src != core_pkg::WB_NONE;
	assign output_valid = state == core_pkg::WRITEBACK && is_wwd;

	// JAL puts the return address on the ALU in DECODE, then the target
	assign pass_input_1 = is_jal && state == core_pkg::DECODE;
	assign pass_input_2 = is_jal && (state == core_pkg::EXECUTE || state == core_pkg::WRITEBACK);

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_consts.svh"

module alu (
	input  logic [`TSC_WORD_BITS-1:0] alu_input_1,
	input  logic [`TSC_WORD_BITS-1:0] alu_input_2,
	input  isa_pkg::opcode_e opcode,
	input  isa_pkg::func_e func_code,
	input  logic pass_input_1,
	input  logic pass_input_2,
	output logic [`TSC_WORD_BITS-1:0] alu_result,
	output logic overflow_flag,
	output logic bcond
);

	logic [`TSC_WORD_BITS-1:0] add_out;
	logic [`TSC_WORD_BITS-1:0] sub_out;
	logic [`TSC_WORD_BITS-1:0] neg_input_2;
	logic add_flag;
	logic sub_flag;

	// ------------------------------
	// Adder and subtractor
	assign add_out = alu_input_1 + alu_input_2;
	assign neg_input_2 = -alu_input_2;
	assign sub_out = alu_input_1 + neg_input_2;

	// Same operand signs, result sign flipped
	assign add_flag = (alu_input_1[`TSC_WORD_BITS-1] == alu_input_2[`TSC_WORD_BITS-1]) &&
		(add_out[`TSC_WORD_BITS-1] != alu_input_1[`TSC_WORD_BITS-1]);
	assign sub_flag = (alu_input_1[`TSC_WORD_BITS-1] == neg_input_2[`TSC_WORD_BITS-1]) &&
		(sub_out[`TSC_WORD_BITS-1] != alu_input_1[`TSC_WORD_BITS-1]);

	// ------------------------------
	// Result select
	always_comb begin
		alu_result = '0;
		overflow_flag = 1'b0;
		bcond = 1'b0;
		case (opcode)
			isa_pkg::ALU: begin
				case (func_code)
					isa_pkg::ADD: begin
						alu_result = add_out;
						overflow_flag = add_flag;
					end
					isa_pkg::SUB: begin
						alu_result = sub_out;
						overflow_flag = sub_flag;
					end
					isa_pkg::AND: alu_result = alu_input_1 & alu_input_2;
					isa_pkg::ORR: alu_result = alu_input_1 | alu_input_2;
					isa_pkg::NOT: alu_result = ~alu_input_1;
					isa_pkg::TCP: alu_result = ~alu_input_1 + 1'b1;
					isa_pkg::SHL: alu_result = {alu_input_1[`TSC_WORD_BITS-2:0], 1'b0};
					isa_pkg::SHR: alu_result = {alu_input_1[`TSC_WORD_BITS-1],
						alu_input_1[`TSC_WORD_BITS-1:1]};
					isa_pkg::JPR,
					isa_pkg::JRL: alu_result = alu_input_1;   // Jump register
					default: alu_result = '0;
				endcase
			end
			isa_pkg::BNE: begin
				alu_result = add_out;
				bcond = alu_input_1 != alu_input_2;
			end
			isa_pkg::BEQ: begin
				alu_result = add_out;
				bcond = alu_input_1 == alu_input_2;
			end
			isa_pkg::BGZ: begin
				alu_result = add_out;
				bcond = $signed(alu_input_1) > 0;
			end
			isa_pkg::BLZ: begin
				alu_result = add_out;
				bcond = $signed(alu_input_1) < 0;
			end
			isa_pkg::JMP: alu_result = alu_input_2;
			isa_pkg::JAL: alu_result = pass_input_1 ? alu_input_1 :
				(pass_input_2 ? alu_input_2 : '0);
			isa_pkg::ADI,
			isa_pkg::LWD,
			isa_pkg::SWD: begin
				alu_result = add_out;   // Also the memory address
				overflow_flag = add_flag;
			end
			isa_pkg::ORI: alu_result = alu_input_1 | alu_input_2;
			isa_pkg::LHI: alu_result = alu_input_2;
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef enum logic [2:0] {
		FETCH,
		FETCH_WAIT,
		DECODE,
		EXECUTE,
		MEM,
		MEM_WAIT,
		WRITEBACK,
		HALT
	} state_e;

	// Register file write data
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC_PLUS_1,
		WB_NONE
	} wb_src_e;

	typedef enum logic [1:0] {
		PC_PLUS_1,
		PC_BRANCH,
		PC_JUMP_TARGET,
		PC_REGISTER
	} pc_src_e;

endpackage

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Major opcode, bits 15:12
	typedef enum logic [3:0] {
		BNE = 4'd0,
		BEQ = 4'd1,
		BGZ = 4'd2,
		BLZ = 4'd3,
		ADI = 4'd4,
		ORI = 4'd5,
		LHI = 4'd6,
		LWD = 4'd7,
		SWD = 4'd8,
		JMP = 4'd9,
		JAL = 4'd10,
		ALU = 4'd15
	} opcode_e;

	// Function field of the R format
	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26,
		WWD = 6'd28,
		HLT = 6'd29
	} func_e;

	typedef struct packed {
		opcode_e opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		func_e func;
	} r_format_t;

	typedef struct packed {
		opcode_e opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} i_format_t;

	typedef struct packed {
		opcode_e opcode;
		logic [11:0] target;
	} j_format_t;

	// One instruction word, three views
	typedef union packed {
		r_format_t r;
		i_format_t i;
		j_format_t j;
	} instr_u;

endpackage

`default_nettype wire

// File: logic/tsc_consts.svh
`ifndef TSC_CONSTS_SVH
`define TSC_CONSTS_SVH

// Datapath, instruction and address width
`define TSC_WORD_BITS 16

// General register file
`define TSC_NUM_REGS 4
`define TSC_REG_BITS 2

// First fetch after reset
`define TSC_RESET_PC 16'h0000

`endif
